/* design/alu.sv */
`default_nettype none

module alu import cpu_pkg::*; (
	input wire alu_op_e op,
	input wire [XLEN-1:0] src1,
	input wire [XLEN-1:0] src2,
	output logic [XLEN-1:0] result,
	output logic overflow
);

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;

	assign sum = src1 + src2;
	assign diff = src1 - src2;

	always_comb begin
		overflow = 1'b0;
		case (op)
			ALU_ADD: begin
				result = sum;
				// same-sign inputs, result sign flipped
				overflow = (src1[XLEN-1] == src2[XLEN-1]) && (sum[XLEN-1] != src1[XLEN-1]);
			end
			ALU_SUB: begin
				result = diff;
				overflow = (src1[XLEN-1] != src2[XLEN-1]) && (diff[XLEN-1] != src1[XLEN-1]);
			end
			ALU_AND: begin
				result = src1 & src2;
			end
			ALU_OR: begin
				result = src1 | src2;
			end
			ALU_XOR: begin
				result = src1 ^ src2;
			end
			ALU_SLT: begin
				result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/controller.sv */
`default_nettype none

module controller import cpu_pkg::*; (
	input wire instr_u instr,
	output ctrl_t ctrl,
	output logic [4:0] ra_addr,
	output logic [4:0] rb_addr,
	output logic [4:0] rt_addr,
	output logic [XLEN-1:0] imm_ext,
	output logic is_branch
);

	always_comb begin
		ctrl = '0;
		ra_addr = instr.i_fmt.ra;
		rb_addr = '0;
		rt_addr = '0;
		is_branch = 1'b0;
		imm_ext = {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};

		case (instr.i_fmt.opcode)
			OP_ALU: begin
				// sub-opcodes past SLT decode as a bubble
				if (instr.r_fmt.sub_op <= ALU_SLT) begin
					ctrl.alu_op = instr.r_fmt.sub_op;
					ctrl.reg_write = 1'b1;
					ctrl.dest = instr.r_fmt.rt;
				end
				ra_addr = instr.r_fmt.ra;
				rb_addr = instr.r_fmt.rb;
			end
			OP_ADDI: begin
				ctrl.alu_op = ALU_ADD;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest = instr.i_fmt.rt;
			end
			OP_ORI: begin
				ctrl.alu_op = ALU_OR;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest = instr.i_fmt.rt;
				imm_ext = {16'b0, instr.i_fmt.imm};
			end
			OP_LW: begin
				ctrl.alu_op = ALU_ADD;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.dest = instr.i_fmt.rt;
			end
			OP_SW: begin
				// rt is the store data here
				ctrl.alu_op = ALU_ADD;
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				rt_addr = instr.i_fmt.rt;
			end
			OP_BEQ: begin
				is_branch = 1'b1;
				rt_addr = instr.i_fmt.rt;
			end
			default: begin
				ra_addr = '0;
			end
		endcase

		// writes to r0 are dropped
		if (ctrl.dest == '0) begin
			ctrl.reg_write = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int XLEN = 32;
	localparam int IM_AW = 10;
	localparam int DM_AW = 12;

	typedef enum logic [5:0] {
		OP_ALU  = 6'h00,
		OP_BEQ  = 6'h04,
		OP_ADDI = 6'h08,
		OP_ORI  = 6'h0d,
		OP_LW   = 6'h23,
		OP_SW   = 6'h2b
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} alu_op_e;

	typedef struct packed {
		opcode_e opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [7:0] unused;
		alu_op_e sub_op;
	} r_fmt_t;

	typedef struct packed {
		opcode_e opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [15:0] imm;
	} i_fmt_t;

	// same 32 bits, two formats
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic [4:0] dest;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
		logic [XLEN-1:0] st_data;
		logic [XLEN-1:0] imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] st_data;
		logic overflow;
	} ex_mem_t;

	typedef struct packed {
		logic reg_write;
		logic [4:0] dest;
		logic [XLEN-1:0] data;
	} mem_wb_t;

	typedef struct packed {
		logic read;
		logic write;
		logic [DM_AW-1:0] addr;
		logic [XLEN-1:0] wdata;
	} dm_req_t;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_EX,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

endpackage

`default_nettype wire

/* design/cpu_top.sv */
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input wire clk,
	input wire arst_n,
	output logic [IM_AW-1:0] im_addr,
	output logic im_read,
	input wire instr_u instruction,
	output dm_req_t dm_req,
	input wire [XLEN-1:0] dm_rdata,
	output logic alu_overflow
);

	instr_u if_id;
	ctrl_t ctrl;
	logic [4:0] ra_addr;
	logic [4:0] rb_addr;
	logic [4:0] rt_addr;
	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] ra_data;
	logic [XLEN-1:0] rb_data;
	logic [XLEN-1:0] rt_data;
	logic [XLEN-1:0] fwd_ra;
	logic [XLEN-1:0] fwd_rb;
	logic [XLEN-1:0] fwd_rt;
	logic [XLEN-1:0] alu_src2;
	logic [XLEN-1:0] ex_result;
	logic is_branch;
	logic hazard;
	logic flush_if;
	logic ex_overflow;
	id_ex_t id_ex_next;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	// decode bundle going into ID/EX
	assign id_ex_next = '{ctrl: ctrl, op_a: fwd_ra, op_b: fwd_rb, st_data: fwd_rt, imm: imm_ext};

	assign alu_src2 = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.op_b;

	pc_unit u_pc_unit (
		.clk(clk), .arst_n(arst_n),
		.hazard(hazard), .is_branch(is_branch),
		.cmp_a(fwd_rt), .cmp_b(fwd_ra), .imm_ext(imm_ext),
		.im_addr(im_addr), .im_read(im_read), .flush_if(flush_if)
	);

	controller u_controller (
		.instr(if_id), .ctrl(ctrl),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.imm_ext(imm_ext), .is_branch(is_branch)
	);

	regfile u_regfile (
		.clk(clk), .arst_n(arst_n),
		.ra_addr(ra_addr), .rb_addr(rb_addr),
		.ra_data(ra_data), .rb_data(rb_data),
		.rt_addr(rt_addr), .rt_data(rt_data),
		.wb(mem_wb)
	);

	forward u_forward (
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data),
		.ex_ctrl(id_ex.ctrl), .ex_result(ex_result),
		.mem_stage(ex_mem), .dm_rdata(dm_rdata), .wb(mem_wb),
		.fwd_ra(fwd_ra), .fwd_rb(fwd_rb), .fwd_rt(fwd_rt),
		.hazard(hazard)
	);

	alu u_alu (
		.op(id_ex.ctrl.alu_op),
		.src1(id_ex.op_a), .src2(alu_src2),
		.result(ex_result), .overflow(ex_overflow)
	);

	stage_regs u_stage_regs (
		.clk(clk), .arst_n(arst_n),
		.instruction(instruction), .hazard(hazard), .flush_if(flush_if),
		.id_ex_next(id_ex_next), .ex_result(ex_result),
		.ex_overflow(ex_overflow), .dm_rdata(dm_rdata),
		.if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
		.dm_req(dm_req), .alu_overflow(alu_overflow)
	);

endmodule

`default_nettype wire

/* design/forward.sv */
`default_nettype none

module forward import cpu_pkg::*; (
	input wire [4:0] ra_addr,
	input wire [4:0] rb_addr,
	input wire [4:0] rt_addr,
	input wire [XLEN-1:0] ra_data,
	input wire [XLEN-1:0] rb_data,
	input wire [XLEN-1:0] rt_data,
	input wire ctrl_t ex_ctrl,
	input wire [XLEN-1:0] ex_result,
	input wire ex_mem_t mem_stage,
	input wire [XLEN-1:0] dm_rdata,
	input wire mem_wb_t wb,
	output logic [XLEN-1:0] fwd_ra,
	output logic [XLEN-1:0] fwd_rb,
	output logic [XLEN-1:0] fwd_rt,
	output logic hazard
);

	logic [XLEN-1:0] mem_val;
	fwd_sel_e sel_ra;
	fwd_sel_e sel_rb;
	fwd_sel_e sel_rt;

	// youngest producer wins
	function automatic fwd_sel_e pick(input logic [4:0] addr, input ctrl_t ex_c,
		input ctrl_t mem_c, input mem_wb_t wb_s);
		if (addr == '0)
			return FWD_REG;
		if (ex_c.reg_write && ex_c.dest == addr)
			return FWD_EX;
		if (mem_c.reg_write && mem_c.dest == addr)
			return FWD_MEM;
		if (wb_s.reg_write && wb_s.dest == addr)
			return FWD_WB;
		return FWD_REG;
	endfunction

	function automatic logic [XLEN-1:0] route(input fwd_sel_e sel, input logic [XLEN-1:0] reg_v,
		input logic [XLEN-1:0] ex_v, input logic [XLEN-1:0] mem_v, input logic [XLEN-1:0] wb_v);
		case (sel)
			FWD_EX: return ex_v;
			FWD_MEM: return mem_v;
			FWD_WB: return wb_v;
			default: return reg_v;
		endcase
	endfunction

	assign mem_val = mem_stage.ctrl.mem_read ? dm_rdata : mem_stage.result;

	always_comb begin
		sel_ra = pick(ra_addr, ex_ctrl, mem_stage.ctrl, wb);
		sel_rb = pick(rb_addr, ex_ctrl, mem_stage.ctrl, wb);
		sel_rt = pick(rt_addr, ex_ctrl, mem_stage.ctrl, wb);
		fwd_ra = route(sel_ra, ra_data, ex_result, mem_val, wb.data);
		fwd_rb = route(sel_rb, rb_data, ex_result, mem_val, wb.data);
		fwd_rt = route(sel_rt, rt_data, ex_result, mem_val, wb.data);
	end

	// load data not ready until MEM
	assign hazard = ex_ctrl.mem_read && ex_ctrl.reg_write &&
		(sel_ra == FWD_EX || sel_rb == FWD_EX || sel_rt == FWD_EX);

endmodule

`default_nettype wire

/* design/pc_unit.sv */
`default_nettype none

module pc_unit import cpu_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire hazard,
	input wire is_branch,
	input wire [XLEN-1:0] cmp_a,
	input wire [XLEN-1:0] cmp_b,
	input wire [XLEN-1:0] imm_ext,
	output logic [IM_AW-1:0] im_addr,
	output logic im_read,
	output logic flush_if
);

	logic [IM_AW-1:0] pc;
	logic [IM_AW-1:0] id_pc;
	logic [IM_AW-1:0] target;
	logic taken;

	// offset is relative to the instruction after the BEQ
	assign target = id_pc + IM_AW'(1) + imm_ext[IM_AW-1:0];
	assign taken = is_branch && (cmp_a == cmp_b) && !hazard;
	assign flush_if = taken;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			id_pc <= '0;
		end else if (!hazard) begin
			id_pc <= pc;
			pc <= taken ? target : pc + IM_AW'(1);
		end
	end

	assign im_addr = pc;
	assign im_read = arst_n;

	// the bubble clears the load out of EX
	a_hazard_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		hazard |=> !hazard);

endmodule

`default_nettype wire

/* design/regfile.sv */
`default_nettype none

module regfile import cpu_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire [4:0] ra_addr,
	input wire [4:0] rb_addr,
	output logic [XLEN-1:0] ra_data,
	output logic [XLEN-1:0] rb_data,
	input wire [4:0] rt_addr,
	output logic [XLEN-1:0] rt_data,
	input wire mem_wb_t wb
);

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.reg_write && wb.dest != '0) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// same-cycle write is picked up by the WB forward path
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

	// the controller drops writes to r0
	a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
		wb.reg_write |-> wb.dest != '0);

endmodule

`default_nettype wire

/* design/stage_regs.sv */
`default_nettype none

module stage_regs import cpu_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire instr_u instruction,
	input wire hazard,
	input wire flush_if,
	input wire id_ex_t id_ex_next,
	input wire [XLEN-1:0] ex_result,
	input wire ex_overflow,
	input wire [XLEN-1:0] dm_rdata,
	output instr_u if_id,
	output id_ex_t id_ex,
	output ex_mem_t ex_mem,
	output mem_wb_t mem_wb,
	output dm_req_t dm_req,
	output logic alu_overflow
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id <= '0;
			id_ex <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			// IF/ID holds on a stall, all-zero decodes as a nop
			if (!hazard) begin
				if_id <= flush_if ? '0 : instruction;
			end

			id_ex <= hazard ? '0 : id_ex_next;

			ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.result <= ex_result;
			ex_mem.st_data <= id_ex.st_data;
			// only ADD, SUB and ADDI count, not address adds
			ex_mem.overflow <= ex_overflow && id_ex.ctrl.reg_write && !id_ex.ctrl.mem_read;

			mem_wb.reg_write <= ex_mem.ctrl.reg_write;
			mem_wb.dest <= ex_mem.ctrl.dest;
			mem_wb.data <= ex_mem.ctrl.mem_read ? dm_rdata : ex_mem.result;
		end
	end

	assign dm_req.read = ex_mem.ctrl.mem_read;
	assign dm_req.write = ex_mem.ctrl.mem_write;
	assign dm_req.addr = ex_mem.result[DM_AW-1:0];
	assign dm_req.wdata = ex_mem.st_data;

	assign alu_overflow = ex_mem.overflow;

	a_dm_rw_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(dm_req.read && dm_req.write));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_top -f verilog.f
./obj_dir/Vtb_top | tee sim.log
grep -q "All tests passed" sim.log

/* verification/tb_checker.sv */
`default_nettype none

module tb_checker import cpu_pkg::*; #(
	parameter int PROG_LEN = 48
) (
	input wire clk,
	input wire arst_n,
	input wire start,
	input int test_idx,
	input wire [PROG_LEN-1:0][XLEN-1:0] prog,
	input wire dm_req_t dm_req,
	input wire [IM_AW-1:0] im_addr,
	input wire im_read,
	input wire alu_overflow,
	output logic done,
	output int pass_count,
	output int fail_count
);

	localparam int IDLE_CYCLES = 8;

	logic [DM_AW-1:0] exp_addr [$];
	logic [XLEN-1:0] exp_data [$];
	logic [DM_AW-1:0] got_addr [$];
	logic [XLEN-1:0] got_data [$];
	int exp_ovf;
	int got_ovf;
	int reset_errs = 0;
	int reset_errs_done = 0;
	logic in_reset_prev = 1'b1;

	// idle in reset and the cycle after it
	always @(negedge clk) begin
		if (!arst_n || in_reset_prev) begin
			if (dm_req.read || dm_req.write || alu_overflow || im_addr != '0) begin
				$display("Error: test %0d, memory port or overflow active around reset", test_idx);
				reset_errs = reset_errs + 1;
			end
		end
		// fetch strobe low only in reset
		if (im_read != arst_n) begin
			$display("Error: test %0d, instruction read strobe does not follow reset", test_idx);
			reset_errs = reset_errs + 1;
		end
		in_reset_prev = !arst_n;
	end

	task automatic run_model();
		logic [XLEN-1:0] regs [32];
		logic [XLEN-1:0] mem [1 << (DM_AW - 2)];
		instr_u ins;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm_s;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] res;
		logic [XLEN:0] wide;
		logic wr;
		logic ovf;
		int pc;
		int steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < (1 << (DM_AW - 2)); i++) begin
			mem[i] = '0;
		end
		exp_addr.delete();
		exp_data.delete();
		exp_ovf = 0;
		pc = 0;
		steps = 0;
		// last word is the halt loop
		while (pc != PROG_LEN - 1 && steps < 4 * PROG_LEN) begin
			ins = prog[pc];
			a = regs[ins.i_fmt.ra];
			b = regs[ins.r_fmt.rb];
			imm_s = {{16{ins.i_fmt.imm[15]}}, ins.i_fmt.imm};
			addr = a + imm_s;
			pc = pc + 1;
			steps = steps + 1;
			wr = 1'b0;
			ovf = 1'b0;
			res = '0;
			case (ins.i_fmt.opcode)
				OP_ALU: begin
					wr = 1'b1;
					case (ins.r_fmt.sub_op)
						ALU_ADD: begin
							wide = {a[XLEN-1], a} + {b[XLEN-1], b};
							res = wide[XLEN-1:0];
							ovf = wide[XLEN] != wide[XLEN-1];
						end
						ALU_SUB: begin
							wide = {a[XLEN-1], a} - {b[XLEN-1], b};
							res = wide[XLEN-1:0];
							ovf = wide[XLEN] != wide[XLEN-1];
						end
						ALU_AND: res = a & b;
						ALU_OR: res = a | b;
						ALU_XOR: res = a ^ b;
						ALU_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				OP_ADDI: begin
					wr = 1'b1;
					wide = {a[XLEN-1], a} + {imm_s[XLEN-1], imm_s};
					res = wide[XLEN-1:0];
					ovf = wide[XLEN] != wide[XLEN-1];
				end
				OP_ORI: begin
					wr = 1'b1;
					res = a | {16'b0, ins.i_fmt.imm};
				end
				OP_LW: begin
					wr = 1'b1;
					res = mem[addr[DM_AW-1:2]];
				end
				OP_SW: begin
					mem[addr[DM_AW-1:2]] = regs[ins.i_fmt.rt];
					exp_addr.push_back(addr[DM_AW-1:0]);
					exp_data.push_back(regs[ins.i_fmt.rt]);
				end
				OP_BEQ: begin
					if (regs[ins.i_fmt.rt] == a) begin
						pc = pc + int'($signed(ins.i_fmt.imm));
					end
				end
				default: begin
				end
			endcase
			if (wr && ins.i_fmt.rt != '0) begin
				regs[ins.i_fmt.rt] = res;
				if (ovf) begin
					exp_ovf = exp_ovf + 1;
				end
			end
		end
	endtask

	task automatic report_test();
		string name;
		int errs;
		int bad;
		name = $sformatf("random_prog_%0d", test_idx);
		errs = reset_errs - reset_errs_done;
		reset_errs_done = reset_errs;
		bad = -1;
		for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
			if (bad < 0 && (exp_addr[i] != got_addr[i] || exp_data[i] != got_data[i])) begin
				bad = i;
			end
		end
		if (errs != 0) begin
			$display("Fail %s: memory port strobes or overflow were wrong around reset", name);
			fail_count = fail_count + 1;
		end else if (got_addr.size() != exp_addr.size()) begin
			$display("Fail %s: store count expected %0d actual %0d", name,
				exp_addr.size(), got_addr.size());
			fail_count = fail_count + 1;
		end else if (bad >= 0) begin
			$display("Fail %s: store %0d expected %h at %h actual %h at %h", name, bad,
				exp_data[bad], exp_addr[bad], got_data[bad], got_addr[bad]);
			fail_count = fail_count + 1;
		end else if (got_ovf != exp_ovf) begin
			$display("Fail %s: overflow count expected %0d actual %0d", name, exp_ovf, got_ovf);
			fail_count = fail_count + 1;
		end else begin
			$display("ok %s: %0d stores, %0d overflows", name, exp_addr.size(), exp_ovf);
			pass_count = pass_count + 1;
		end
	endtask

	initial begin
		int idle;
		done = 1'b0;
		pass_count = 0;
		fail_count = 0;
		forever begin
			wait (start);
			run_model();
			got_addr.delete();
			got_data.delete();
			got_ovf = 0;
			wait (arst_n);
			idle = 0;
			while (idle < IDLE_CYCLES) begin
				@(negedge clk);
				if (dm_req.write) begin
					got_addr.push_back(dm_req.addr);
					got_data.push_back(dm_req.wdata);
				end
				if (alu_overflow) begin
					got_ovf = got_ovf + 1;
				end
				if (got_addr.size() >= exp_addr.size()) begin
					idle = idle + 1;
				end
			end
			report_test();
			done = 1'b1;
			wait (!start);
			done = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic clk
);

	localparam int HALF_PERIOD = 2;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* verification/tb_top.sv */
`default_nettype none

module tb_top import cpu_pkg::*; ();

	localparam int NUM_TESTS = 8;
	localparam int NUM_RANDOM = 40;
	localparam int PROG_LEN = NUM_RANDOM + 8;
	localparam int CYCLE = 4;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (PROG_LEN * 3 + 20);
	localparam int IM_WORDS = 1 << IM_AW;
	localparam int DM_WORDS = 1 << (DM_AW - 2);

	logic clk;
	logic arst_n;
	logic [IM_AW-1:0] im_addr;
	logic im_read;
	instr_u instruction;
	dm_req_t dm_req;
	logic [XLEN-1:0] dm_rdata;
	logic alu_overflow;

	logic [XLEN-1:0] imem [IM_WORDS];
	logic [XLEN-1:0] dmem [DM_WORDS];
	logic [PROG_LEN-1:0][XLEN-1:0] prog;
	logic [31:0] seed;
	logic start;
	logic done;
	int test_idx;
	int pass_count;
	int fail_count;

	tb_clock u_tb_clock (
		.clk(clk)
	);

	cpu_top u_cpu_top (
		.clk(clk),
		.arst_n(arst_n),
		.im_addr(im_addr),
		.im_read(im_read),
		.instruction(instruction),
		.dm_req(dm_req),
		.dm_rdata(dm_rdata),
		.alu_overflow(alu_overflow)
	);

	tb_checker #(.PROG_LEN(PROG_LEN)) u_tb_checker (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.test_idx(test_idx),
		.prog(prog),
		.dm_req(dm_req),
		.im_addr(im_addr),
		.im_read(im_read),
		.alu_overflow(alu_overflow),
		.done(done),
		.pass_count(pass_count),
		.fail_count(fail_count)
	);

	// both memories answer in the same cycle
	assign instruction = imem[im_addr];
	assign dm_rdata = arst_n ? dmem[dm_req.addr[DM_AW-1:2]] : '0;

	// cleared while reset is held
	always @(posedge clk) begin
		if (!arst_n) begin
			for (int i = 0; i < DM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (dm_req.write) begin
			dmem[dm_req.addr[DM_AW-1:2]] <= dm_req.wdata;
		end
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return {8'b0, seed[31:8]};
	endfunction

	function automatic logic [4:0] pick_reg(input logic [31:0] r);
		return 5'(32'd1 + r % 32'd7);
	endfunction

	function automatic logic [31:0] enc_r(input alu_op_e op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb);
		return {OP_ALU, rt, ra, rb, 8'h00, op};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_e opc, input logic [4:0] rt,
		input logic [4:0] ra, input logic [15:0] imm);
		return {opc, rt, ra, imm};
	endfunction

	task automatic build_program();
		logic [31:0] r;
		logic [4:0] rd;
		logic [4:0] chain;
		logic [15:0] daddr;
		chain = 5'd1;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			r = next_rand();
			rd = pick_reg(r >> 4);
			daddr = {8'b0, r[21:16], 2'b00};
			case (r[3:0])
				4'd0, 4'd1, 4'd2: begin
					prog[i] = enc_r(alu_op_e'(3'((r >> 8) % 32'd6)), rd, chain, pick_reg(r >> 12));
				end
				// doubling chains push values toward overflow
				4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8: begin
					prog[i] = enc_r(ALU_ADD, rd, chain, chain);
				end
				4'd9: begin
					prog[i] = enc_i(OP_ADDI, rd, pick_reg(r >> 12), r[23:8]);
				end
				4'd10, 4'd11: begin
					prog[i] = enc_i(OP_ORI, rd, pick_reg(r >> 12), r[23:8]);
				end
				4'd12: begin
					prog[i] = enc_i(OP_LW, rd, 5'd0, daddr);
				end
				4'd13, 4'd14: begin
					prog[i] = enc_i(OP_SW, chain, 5'd0, daddr);
					rd = chain;
				end
				default: begin
					prog[i] = enc_i(OP_BEQ, rd, pick_reg(r >> 12), {14'b0, r[23:22]});
					rd = chain;
				end
			endcase
			chain = rd;
		end
		for (int k = 1; k <= 7; k++) begin
			prog[NUM_RANDOM + k - 1] = enc_i(OP_SW, 5'(k), 5'd0, 16'(32'h100 + 4 * k));
		end
		// branch to itself
		prog[PROG_LEN-1] = enc_i(OP_BEQ, 5'd0, 5'd0, 16'hffff);
	endtask

	initial begin
		arst_n = 1'b0;
		start = 1'b0;
		test_idx = 0;
		seed = 32'h4e2be769;
		prog = '0;
		for (int i = 0; i < IM_WORDS; i++) begin
			imem[i] = '0;
		end
		for (int t = 0; t < NUM_TESTS; t++) begin
			@(posedge clk);
			#1;
			arst_n = 1'b0;
			test_idx = t;
			build_program();
			for (int i = 0; i < PROG_LEN; i++) begin
				imem[i] = prog[i];
			end
			start = 1'b1;
			repeat (4) @(posedge clk);
			#1;
			arst_n = 1'b1;
			wait (done);
			start = 1'b0;
			wait (!done);
		end
		$display("tests run %0d, ok %0d, failing %0d", NUM_TESTS, pass_count, fail_count);
		if (fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CYCLE);
		$display("Error: run timed out in test %0d before the DUT made all its stores", test_idx);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
design/cpu_pkg.sv
design/alu.sv
design/regfile.sv
design/controller.sv
design/forward.sv
design/pc_unit.sv
design/stage_regs.sv
design/cpu_top.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv
